// ==== all.f ====
+incdir+.
icache_pkg.sv
icache_fetch_stage.sv
icache_tag_array.sv
icache_data_array.sv
icache_resp_unit.sv
icache_top.sv
tb_icache.sv

// ==== tb_icache.sv ====
// Instruction cache testbench
// Directed tests with a four-phase memory model and a reference LRU model

`timescale 1ns/1ns

`include "icache_defines.svh"

module tb_icache;

  localparam int          TIMEOUT   = 200;
  localparam int          ACK_DELAY = 3;
  localparam logic [31:0] WORD_KEY  = 32'h5a3c_96e1;
  localparam logic [31:0] COLD_ADDR = 32'h0000_1238;

  logic                        clk;
  logic                        reset;
  logic                        fetch_v;
  icache_pkg::fetch_addr_u     fetch_addr;
  logic                        fetch_ready;
  logic [`ICACHE_INSTR_W-1:0]  data;
  logic                        data_v;
  logic                        miss_req;
  logic [`ICACHE_ADDR_W-1:0]   miss_addr;
  logic                        miss_ack;
  logic [`ICACHE_BLOCK_W-1:0]  miss_data;

  int          errors;
  int          checks;
  int          tests;
  int          test_start_errors;
  int          miss_count;
  logic [31:0] last_miss_addr;
  logic [31:0] rng_state;
  string       cur_test;

  // Reference cache state
  logic [`ICACHE_TAG_W-1:0] ref_tag [`ICACHE_WAYS][`ICACHE_SETS];
  logic                     ref_valid [`ICACHE_WAYS][`ICACHE_SETS];
  logic                     ref_lru [`ICACHE_SETS];

  icache_top icache_top_i (
    .clk_i         (clk),
    .reset_i       (reset),
    .fetch_v_i     (fetch_v),
    .fetch_addr_i  (fetch_addr),
    .fetch_ready_o (fetch_ready),
    .data_o        (data),
    .data_v_o      (data_v),
    .miss_req_o    (miss_req),
    .miss_addr_o   (miss_addr),
    .miss_ack_i    (miss_ack),
    .miss_data_i   (miss_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return addr ^ WORD_KEY;
  endfunction

  function automatic logic [`ICACHE_BLOCK_W-1:0] model_block(input logic [31:0] base);
    logic [`ICACHE_BLOCK_W-1:0] blk;
    for (int i = 0; i < 4; i++)
      blk[i*32 +: 32] = model_word(base + 4 * i);
    return blk;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Predict hit or miss and update the reference LRU state
  function automatic logic model_access(input logic [31:0] addr);
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_INDEX_W-1:0] idx;
    logic                       victim;
    tag = addr[31:8];
    idx = addr[7:4];
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (ref_valid[w][idx] && ref_tag[w][idx] == tag)
      begin
        ref_lru[idx] = (w == 0);
        return 1'b1;
      end
    victim                 = ref_lru[idx];
    ref_tag[victim][idx]   = tag;
    ref_valid[victim][idx] = 1'b1;
    ref_lru[idx]           = ~victim;
    return 1'b0;
  endfunction

  task automatic check(input string item, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("FAIL %s (%s): expected %h, actual %h", cur_test, item, expected, actual);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("TIMEOUT in %s: %s", cur_test, what);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic begin_test(input string name);
    cur_test          = name;
    test_start_errors = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("test %-18s done, %0d errors", cur_test, errors - test_start_errors);
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!fetch_ready)
    begin
      if (waited == TIMEOUT)
        timeout_abort("fetch_ready_o never rose");
      waited++;
      @(negedge clk);
    end
  endtask

  // One fetch checked against the memory model and the reference LRU
  task automatic fetch(input logic [31:0] addr, output logic hit);
    int   waited;
    int   misses_before;
    logic expect_hit;
    wait_ready();
    misses_before  = miss_count;
    expect_hit     = model_access(addr);
    fetch_v        = 1'b1;
    fetch_addr.raw = addr;
    @(negedge clk);
    fetch_v = 1'b0;
    hit     = data_v;
    waited  = 0;
    if (!hit)
    begin
      check("ready low in miss lookup", 0, fetch_ready);
      while (!data_v)
      begin
        if (waited == TIMEOUT)
          timeout_abort("no data returned after a miss");
        waited++;
        @(negedge clk);
      end
      check("one miss request", misses_before + 1, miss_count);
      check("block-aligned miss address", addr & ~32'hF, last_miss_addr);
    end
    check("fetch data", model_word(addr), data);
    check("hit or miss", expect_hit, hit);
    if (hit)
    begin
      @(negedge clk);
      check("no miss request on hit", 0, miss_req);
    end
  endtask

  ////////////////////////////////////////
  // Memory model on the four-phase req/ack channel
  ////////////////////////////////////////
  initial
  begin : memory_model
    int          delay;
    logic [31:0] req_addr;
    miss_ack  = 1'b0;
    miss_data = '0;
    delay     = 0;
    forever
    begin
      @(negedge clk);
      if (miss_ack)
      begin
        // Release once the cache has dropped its request
        if (!miss_req)
          miss_ack = 1'b0;
      end
      else if (miss_req)
      begin
        if (delay == 0)
          req_addr = miss_addr;
        else
          check("miss address stable", req_addr, miss_addr);
        if (delay == ACK_DELAY)
        begin
          miss_data      = model_block(miss_addr);
          miss_ack       = 1'b1;
          last_miss_addr = miss_addr;
          miss_count++;
          delay = 0;
        end
        else
          delay++;
      end
    end
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_state();
    begin_test("reset_state");
    check("fetch_ready_o", 1, fetch_ready);
    check("data_v_o", 0, data_v);
    check("miss_req_o", 0, miss_req);
    end_test();
  endtask

  task automatic cold_miss();
    logic hit;
    begin_test("cold_miss");
    fetch(COLD_ADDR, hit);
    check("cold fetch misses", 0, hit);
    end_test();
  endtask

  // All four words of the cold block on consecutive cycles
  task automatic same_block_hits();
    logic [31:0] addr;
    logic        expect_hit;
    begin_test("same_block_hits");
    wait_ready();
    for (int i = 0; i < 4; i++)
    begin
      addr           = (COLD_ADDR & ~32'hF) + 4 * i;
      expect_hit     = model_access(addr);
      fetch_v        = 1'b1;
      fetch_addr.raw = addr;
      @(negedge clk);
      check("data_v one cycle after accept", expect_hit, data_v);
      check("hit data", model_word(addr), data);
      check("ready stays high on hits", 1, fetch_ready);
      check("no miss request", 0, miss_req);
    end
    fetch_v = 1'b0;
    @(negedge clk);
    check("no miss request", 0, miss_req);
    end_test();
  endtask

  // Set 5 with tags 1 and 2
  task automatic same_set_two_tags();
    logic hit;
    begin_test("same_set_two_tags");
    fetch(32'h0000_0154, hit);
    fetch(32'h0000_0258, hit);
    fetch(32'h0000_0150, hit);
    check("first tag resident", 1, hit);
    fetch(32'h0000_025c, hit);
    check("second tag resident", 1, hit);
    end_test();
  endtask

  // Tag 1 is LRU after the refetches so tag 3 replaces it
  task automatic lru_eviction();
    logic hit;
    begin_test("lru_eviction");
    fetch(32'h0000_035c, hit);
    check("third tag misses", 0, hit);
    fetch(32'h0000_0254, hit);
    check("recent block hits", 1, hit);
    fetch(32'h0000_0158, hit);
    check("evicted block misses", 0, hit);
    end_test();
  endtask

  // Small address range so some sets see several tags
  task automatic random_refetch();
    logic [31:0] addrs [12];
    logic        hit;
    begin_test("random_refetch");
    for (int i = 0; i < 12; i++)
    begin
      rng_state = xorshift(rng_state);
      addrs[i]  = rng_state & 32'h0000_03fc;
    end
    for (int pass = 0; pass < 2; pass++)
      for (int i = 0; i < 12; i++)
        fetch(addrs[i], hit);
    end_test();
  endtask

  initial
  begin
    errors     = 0;
    checks     = 0;
    tests      = 0;
    miss_count = 0;
    rng_state  = 32'h9de37808;
    cur_test   = "startup";
    reset      = 1'b1;
    fetch_v    = 1'b0;
    fetch_addr = '0;
    for (int s = 0; s < `ICACHE_SETS; s++)
    begin
      ref_lru[s] = 1'b0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
        ref_valid[w][s] = 1'b0;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    reset_state();
    cold_miss();
    same_block_hits();
    same_set_two_tags();
    lru_eviction();
    random_refetch();
    $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== icache_top.sv ====
// Instruction cache top level
// Two-way physically addressed cache: fetch stage, tag and data arrays,
// and response unit with a four-phase miss channel

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fetch_v_i,
  input  icache_pkg::fetch_addr_u     fetch_addr_i,
  output logic                        fetch_ready_o,
  output logic [`ICACHE_INSTR_W-1:0]  data_o,
  output logic                        data_v_o,
  output logic                        miss_req_o,
  output logic [`ICACHE_ADDR_W-1:0]   miss_addr_o,
  input  logic                        miss_ack_i,
  input  logic [`ICACHE_BLOCK_W-1:0]  miss_data_i
);

  // Fetch stage to arrays and response unit
  logic                       rd_en;
  logic [`ICACHE_INDEX_W-1:0] rd_index;
  logic                       lookup_v;
  icache_pkg::fetch_addr_u    lookup_addr;

  // Arrays to response unit
  logic                       hit;
  logic [`ICACHE_WAYS-1:0]    hit_way_onehot;
  logic                       lru_way;
  logic [`ICACHE_BLOCK_W-1:0] way0_block;
  logic [`ICACHE_BLOCK_W-1:0] way1_block;

  // Response unit back to fetch stage and arrays
  logic                       hold;
  logic                       fill_we;
  logic                       fill_way;

  icache_fetch_stage fetch_stage_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_addr_i  (fetch_addr_i),
    .hold_i        (hold),
    .fetch_ready_o (fetch_ready_o),
    .rd_en_o       (rd_en),
    .rd_index_o    (rd_index),
    .lookup_v_o    (lookup_v),
    .lookup_addr_o (lookup_addr)
  );

  icache_tag_array tag_array_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_en_i       (rd_en),
    .rd_index_i    (rd_index),
    .lookup_addr_i (lookup_addr),
    .fill_we_i     (fill_we),
    .fill_way_i    (fill_way),
    .hit_o         (hit),
    .hit_way_o     (hit_way_onehot),
    .lru_way_o     (lru_way)
  );

  icache_data_array data_array_i (
    .clk_i         (clk_i),
    .rd_en_i       (rd_en),
    .rd_index_i    (rd_index),
    .lookup_addr_i (lookup_addr),
    .fill_we_i     (fill_we),
    .fill_way_i    (fill_way),
    .fill_data_i   (miss_data_i),
    .way0_block_o  (way0_block),
    .way1_block_o  (way1_block)
  );

  icache_resp_unit resp_unit_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_v_i    (lookup_v),
    .lookup_addr_i (lookup_addr),
    .hit_i         (hit),
    .hit_way_i     (hit_way_onehot),
    .lru_way_i     (lru_way),
    .way0_block_i  (way0_block),
    .way1_block_i  (way1_block),
    .miss_ack_i    (miss_ack_i),
    .miss_data_i   (miss_data_i),
    .hold_o        (hold),
    .data_o        (data_o),
    .data_v_o      (data_v_o),
    .miss_req_o    (miss_req_o),
    .miss_addr_o   (miss_addr_o),
    .fill_we_o     (fill_we),
    .fill_way_o    (fill_way)
  );

endmodule

// ==== icache_resp_unit.sv ====
// Instruction cache response unit
// Word select on hit, miss FSM with four-phase req/ack to memory,
// refill write and return of the missed word

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_resp_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        lookup_v_i,
  input  icache_pkg::fetch_addr_u     lookup_addr_i,
  input  logic                        hit_i,
  input  logic [`ICACHE_WAYS-1:0]     hit_way_i,
  input  logic                        lru_way_i,
  input  logic [`ICACHE_BLOCK_W-1:0]  way0_block_i,
  input  logic [`ICACHE_BLOCK_W-1:0]  way1_block_i,
  input  logic                        miss_ack_i,
  input  logic [`ICACHE_BLOCK_W-1:0]  miss_data_i,
  output logic                        hold_o,
  output logic [`ICACHE_INSTR_W-1:0]  data_o,
  output logic                        data_v_o,
  output logic                        miss_req_o,
  output logic [`ICACHE_ADDR_W-1:0]   miss_addr_o,
  output logic                        fill_we_o,
  output logic                        fill_way_o
);

  import icache_pkg::*;

  resp_state_e                state_r;
  resp_state_e                state_n;
  logic                       miss;
  logic                       ack_take;
  logic                       victim_way_r;
  logic                       refill_v_r;
  logic [`ICACHE_INSTR_W-1:0] refill_word_r;
  logic [`ICACHE_BLOCK_W-1:0] hit_block;

  function automatic logic [`ICACHE_INSTR_W-1:0] pick_word(
    input logic [`ICACHE_BLOCK_W-1:0]    block,
    input logic [`ICACHE_WORD_SEL_W-1:0] sel
  );
    return block[sel*`ICACHE_INSTR_W +: `ICACHE_INSTR_W];
  endfunction

  assign miss     = lookup_v_i & ~hit_i;
  assign ack_take = (state_r == e_miss_req) & miss_ack_i;

  ////////////////////////////////////////
  // Hit path
  ////////////////////////////////////////

  // One-hot AND-OR way mux
  assign hit_block = ({`ICACHE_BLOCK_W{hit_way_i[0]}} & way0_block_i)
                   | ({`ICACHE_BLOCK_W{hit_way_i[1]}} & way1_block_i);

  // Refill word wins, lookups are stalled during a miss anyway
  assign data_o   = refill_v_r ? refill_word_r
                               : pick_word(hit_block, lookup_addr_i.fields.word_sel);
  assign data_v_o = (lookup_v_i & hit_i) | refill_v_r;

  ////////////////////////////////////////
  // Miss FSM
  ////////////////////////////////////////
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:        if (miss) state_n = e_miss_req;
      e_miss_req:     if (miss_ack_i) state_n = e_miss_release;
      e_miss_release: if (!miss_ack_i) state_n = e_ready;
      default:        state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= e_ready;
      refill_v_r <= 1'b0;
    end
    else
    begin
      state_r    <= state_n;
      refill_v_r <= ack_take;
    end
  end

  // Victim and returned word
  always_ff @(posedge clk_i)
  begin
    if (miss)
      victim_way_r <= lru_way_i;
    if (ack_take)
      refill_word_r <= pick_word(miss_data_i, lookup_addr_i.fields.word_sel);
  end

  // Covers the miss lookup cycle and both miss states
  assign hold_o = miss | (state_r != e_ready);

  // Lookup address is frozen for the whole miss, so the request address is stable
  assign miss_req_o  = (state_r == e_miss_req);
  assign miss_addr_o = {lookup_addr_i.raw[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                        {`ICACHE_OFFSET_W{1'b0}}};
  assign fill_we_o   = ack_take;
  assign fill_way_o  = victim_way_r;

endmodule

// ==== icache_data_array.sv ====
// Instruction cache data array
// One block memory per way, synchronous read, full-block refill write

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_data_array (
  input  logic                        clk_i,
  input  logic                        rd_en_i,
  input  logic [`ICACHE_INDEX_W-1:0]  rd_index_i,
  input  icache_pkg::fetch_addr_u     lookup_addr_i,
  input  logic                        fill_we_i,
  input  logic                        fill_way_i,
  input  logic [`ICACHE_BLOCK_W-1:0]  fill_data_i,
  output logic [`ICACHE_BLOCK_W-1:0]  way0_block_o,
  output logic [`ICACHE_BLOCK_W-1:0]  way1_block_o
);

  logic [`ICACHE_BLOCK_W-1:0] block_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_BLOCK_W-1:0] block_rd [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0]    fill_way_oh;

  // Only the victim way is written
  assign fill_way_oh = fill_we_i ? (`ICACHE_WAYS'(1) << fill_way_i) : '0;

  ////////////////////////////////////////
  // Block storage
  ////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      // Refill goes to the set that missed
      if (fill_way_oh[w])
        block_mem[w][lookup_addr_i.fields.index] <= fill_data_i;
      if (rd_en_i)
        block_rd[w] <= block_mem[w][rd_index_i];
    end
  end

  // Both ways come out in the lookup cycle
  assign way0_block_o = block_rd[0];
  assign way1_block_o = block_rd[1];

endmodule

// ==== icache_tag_array.sv ====
// Instruction cache tag array
// Tags, valid bits and one LRU bit per set, with per-way hit compare
// and refill write

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_tag_array (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        rd_en_i,
  input  logic [`ICACHE_INDEX_W-1:0]  rd_index_i,
  input  icache_pkg::fetch_addr_u     lookup_addr_i,
  input  logic                        fill_we_i,
  input  logic                        fill_way_i,
  output logic                        hit_o,
  output logic [`ICACHE_WAYS-1:0]     hit_way_o,
  output logic                        lru_way_o
);

  logic [`ICACHE_TAG_W-1:0]                   tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_TAG_W-1:0]                   tag_rd [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0]  valid_r;
  logic [`ICACHE_WAYS-1:0]                    valid_rd;
  logic [`ICACHE_SETS-1:0]                    lru_r;
  logic [`ICACHE_WAYS-1:0]                    fill_way_oh;
  logic                                       rd_v_r;

  assign fill_way_oh = fill_we_i ? (`ICACHE_WAYS'(1) << fill_way_i) : '0;

  ////////////////////////////////////////
  // Tag storage
  ////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (fill_way_oh[w])
        tag_mem[w][lookup_addr_i.fields.index] <= lookup_addr_i.fields.tag;
      if (rd_en_i)
        tag_rd[w] <= tag_mem[w][rd_index_i];
    end
  end

  ////////////////////////////////////////
  // Valid and LRU state
  ////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r  <= '0;
      valid_rd <= '0;
      lru_r    <= '0;
      rd_v_r   <= 1'b0;
    end
    else
    begin
      rd_v_r <= rd_en_i;
      if (rd_en_i)
        for (int w = 0; w < `ICACHE_WAYS; w++)
          valid_rd[w] <= valid_r[w][rd_index_i];
      // Refilled way becomes MRU
      if (fill_we_i)
      begin
        valid_r[fill_way_i][lookup_addr_i.fields.index] <= 1'b1;
        lru_r[lookup_addr_i.fields.index]               <= ~fill_way_i;
      end
      // Hit in way 0 leaves way 1 as LRU, and the other way round
      else if (rd_v_r && hit_o)
        lru_r[lookup_addr_i.fields.index] <= hit_way_o[0];
    end
  end

  // Per-way compare against the lookup tag
  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
      hit_way_o[w] = valid_rd[w] & (tag_rd[w] == lookup_addr_i.fields.tag);
  end

  assign hit_o     = |hit_way_o;
  assign lru_way_o = lru_r[lookup_addr_i.fields.index];

endmodule

// ==== icache_fetch_stage.sv ====
// Instruction cache fetch stage
// Accepts fetch requests, starts the array reads and holds the lookup address

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_fetch_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fetch_v_i,
  input  icache_pkg::fetch_addr_u     fetch_addr_i,
  input  logic                        hold_i,
  output logic                        fetch_ready_o,
  output logic                        rd_en_o,
  output logic [`ICACHE_INDEX_W-1:0]  rd_index_o,
  output logic                        lookup_v_o,
  output icache_pkg::fetch_addr_u     lookup_addr_o
);

  import icache_pkg::*;

  logic        accept;
  logic        lookup_v_r;
  fetch_addr_u lookup_addr_r;

  // Ready whenever the response side is not busy with a miss
  assign fetch_ready_o = ~hold_i;
  assign accept        = fetch_v_i & fetch_ready_o;

  // Arrays are read in the accept cycle at the incoming set
  assign rd_en_o    = accept;
  assign rd_index_o = fetch_addr_i.fields.index;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lookup_v_r <= 1'b0;
    end
    else
    begin
      lookup_v_r <= accept;
    end
  end

  // Held between acceptances so a refill lands in the set that missed
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      lookup_addr_r.raw <= fetch_addr_i.raw;
    end
  end

  assign lookup_v_o    = lookup_v_r;
  assign lookup_addr_o = lookup_addr_r;

endmodule

// ==== icache_pkg.sv ====
// Instruction cache types
// Fetch address with raw and field views, and the response state encoding

`include "icache_defines.svh"

package icache_pkg;

  ////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////

  // Field view, MSB first
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]                       tag;
    logic [`ICACHE_INDEX_W-1:0]                     index;
    logic [`ICACHE_WORD_SEL_W-1:0]                  word_sel;
    logic [`ICACHE_OFFSET_W-`ICACHE_WORD_SEL_W-1:0] byte_off;
  } fetch_addr_s;

  // Same 32 bits, read either as a word or as fields
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    fetch_addr_s               fields;
  } fetch_addr_u;

  ////////////////////////////////////////
  // Response unit states
  ////////////////////////////////////////

  // e_miss_release waits for the memory side to drop ack
  typedef enum logic [1:0] {
    e_ready        = 2'b00,
    e_miss_req     = 2'b01,
    e_miss_release = 2'b10
  } resp_state_e;

endpackage

// ==== icache_defines.svh ====
// Instruction cache geometry
// Address, instruction and block widths plus the derived field widths
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Physical fetch address and instruction word
`define ICACHE_ADDR_W 32
`define ICACHE_INSTR_W 32

// Four instruction words per block
`define ICACHE_BLOCK_W 128

// Two-way, 16 sets
`define ICACHE_SETS 16
`define ICACHE_WAYS 2

// Address fields: tag | index | word select | byte offset
`define ICACHE_INDEX_W 4
`define ICACHE_OFFSET_W 4
`define ICACHE_WORD_SEL_W 2
`define ICACHE_TAG_W 24

`endif
